//--- verilog.f
+incdir+common
common/memStagePkg.sv
hw/memStage/memReg.sv
hw/memStage/memAccess.sv
hw/memStage/exceptionUnit.sv
hw/memStage/cp0Regs.sv
hw/memStage/memStage.sv
test/tbMemStage.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
    -f verilog.f --top-module tbMemStage -o simMemStage

./obj_dir/simMemStage > sim.log
cat sim.log

if grep -q "Simulation completed successfully" sim.log; then
    exit 0
else
    echo "Simulation failed"
    exit 1
fi

//--- test/tbMemStage.sv
// Testbench for the memory stage: register control, stores, address errors, interrupts, ERET.
`timescale 1ns/1ps
`include "memStage_params.svh"

module tbMemStage
    import memStagePkg::*;
();

    localparam int ResetCycles = 10;
    localparam int TestCycles  = 100;

    logic       clk;
    logic       rstN;
    logic       memWr;
    logic       memFlush;
    exeMemBus_t exeMem;
    logic [5:0] hwInt;
    logic       wbCp0Wr;
    regAddr_t   wbCp0Addr;
    word_t      wbCp0Data;
    memWbBus_t  memWb;
    logic       dmemEn;
    byteEn_t    dmemWe;
    word_t      dmemAddr;
    word_t      dmemWdata;
    word_t      memResult;
    regAddr_t   memDst;
    logic       ifIdFlush;
    logic       idExeFlush;
    logic       exeMemFlush;
    logic       isExceptOrEret;
    word_t      excTarget;

    word_t lfsrState = 32'hf2;
    word_t pcCounter = 32'h0040_0000;
    word_t expEpc;
    int    errorCount  = 0;
    int    testCount   = 0;
    int    failedTests = 0;

    memStage dut (
        .clk              (clk),
        .rstN_i           (rstN),
        .memWr_i          (memWr),
        .memFlush_i       (memFlush),
        .exeMem_i         (exeMem),
        .hwInt_i          (hwInt),
        .wbCp0Wr_i        (wbCp0Wr),
        .wbCp0Addr_i      (wbCp0Addr),
        .wbCp0Data_i      (wbCp0Data),
        .memWb_o          (memWb),
        .dmemEn_o         (dmemEn),
        .dmemWe_o         (dmemWe),
        .dmemAddr_o       (dmemAddr),
        .dmemWdata_o      (dmemWdata),
        .memResult_o      (memResult),
        .memDst_o         (memDst),
        .ifIdFlush_o      (ifIdFlush),
        .idExeFlush_o     (idExeFlush),
        .exeMemFlush_o    (exeMemFlush),
        .isExceptOrEret_o (isExceptOrEret),
        .excTarget_o      (excTarget)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // Galois LFSR, one step per bit taken.
    function automatic word_t randBits(input int n);
        word_t res;
        res = '0;
        for (int i = 0; i < n; i++) begin
            res = {res[30:0], lfsrState[0]};
            if (lfsrState[0])
                lfsrState = (lfsrState >> 1) ^ 32'h80200003;
            else
                lfsrState = lfsrState >> 1;
        end
        return res;
    endfunction

    // Valid ALU instruction with random payload and a register write.
    function automatic exeMemBus_t makeInstr();
        exeMemBus_t b;
        b = '0;
        b.valid = 1'b1;
        b.pc = pcCounter;
        pcCounter = pcCounter + 32'd4;
        b.aluOut = randBits(32);
        b.outB = randBits(32);
        b.hi = randBits(32);
        b.lo = randBits(32);
        b.dst = regAddr_t'(randBits(5));
        b.regsWr.regWr = 1'b1;
        return b;
    endfunction

    task automatic checkEq(input string name, input logic [31:0] got, input logic [31:0] exp);
        assert (got === exp) else begin
            $display("ERROR %s: got 0x%08h, expected 0x%08h", name, got, exp);
            errorCount++;
        end
    endtask

    task automatic checkRedirect(input logic exp);
        checkEq("ifIdFlush_o", 32'(ifIdFlush), 32'(exp));
        checkEq("idExeFlush_o", 32'(idExeFlush), 32'(exp));
        checkEq("exeMemFlush_o", 32'(exeMemFlush), 32'(exp));
        checkEq("isExceptOrEret_o", 32'(isExceptOrEret), 32'(exp));
    endtask

    task automatic endTest(input string name, input int errsBefore);
        testCount++;
        if (errorCount == errsBefore) begin
            $display("Test %s: PASS", name);
        end else begin
            failedTests++;
            $display("Test %s: FAIL with %0d errors", name, errorCount - errsBefore);
        end
    endtask

    // Presents one instruction for one edge, then a bubble; returns in the MEM cycle.
    task automatic loadInstr(input exeMemBus_t b);
        @(posedge clk);
        exeMem   <= b;
        memWr    <= 1'b1;
        memFlush <= 1'b0;
        @(posedge clk);
        exeMem <= '0;
        @(negedge clk);
    endtask

    task automatic testRegControl();
        int         errs;
        exeMemBus_t a;
        exeMemBus_t b;
        errs = errorCount;
        checkEq("dmemEn_o", 32'(dmemEn), 32'd0);
        checkRedirect(1'b0);
        a = makeInstr();
        b = makeInstr();
        @(posedge clk);
        exeMem <= a;
        memWr  <= 1'b1;
        @(negedge clk);
        checkEq("memWb_o.valid", 32'(memWb.valid), 32'd0);
        @(posedge clk);
        exeMem <= b;
        memWr  <= 1'b0;
        @(negedge clk);
        checkEq("memWb_o.valid", 32'(memWb.valid), 32'd1);
        checkEq("memWb_o.aluOut", memWb.aluOut, a.aluOut);
        checkEq("memWb_o.outB", memWb.outB, a.outB);
        checkEq("memWb_o.hi", memWb.hi, a.hi);
        checkEq("memWb_o.lo", memWb.lo, a.lo);
        checkEq("memWb_o.dst", 32'(memWb.dst), 32'(a.dst));
        checkEq("memWb_o.regsWr", 32'(memWb.regsWr), 32'(a.regsWr));
        // Still held, b must not get in.
        @(negedge clk);
        checkEq("memWb_o.pc", memWb.pc, a.pc);
        checkEq("memWb_o.aluOut", memWb.aluOut, a.aluOut);
        @(posedge clk);
        memFlush <= 1'b1;
        memWr    <= 1'b1;
        @(posedge clk);
        memFlush <= 1'b0;
        exeMem   <= '0;
        @(negedge clk);
        checkEq("memWb_o.valid", 32'(memWb.valid), 32'd0);
        checkEq("dmemEn_o", 32'(dmemEn), 32'd0);
        endTest("register control", errs);
    endtask

    task automatic testStores();
        int         errs;
        exeMemBus_t b;
        word_t      addr;
        word_t      expData;
        byteEn_t    expWe;
        word_t      sel;
        word_t      wbPick;
        word_t      expResult;
        errs = errorCount;
        for (int i = 0; i < 8; i++) begin
            b = makeInstr();
            addr = randBits(32);
            sel = randBits(2);
            if (sel == 32'd1) begin
                b.storeType = ST_H;
                addr[0] = 1'b0;
                expWe = addr[1] ? 4'b1100 : 4'b0011;
                expData = {2{b.outB[15:0]}};
            end else if (sel == 32'd2) begin
                b.storeType = ST_W;
                addr[1:0] = 2'b00;
                expWe = 4'b1111;
                expData = b.outB;
            end else begin
                b.storeType = ST_B;
                expWe = 4'b0001 << addr[1:0];
                expData = {4{b.outB[7:0]}};
            end
            b.aluOut = addr;
            // Only WB_OUTB forwards outB, the other selectors forward the address.
            wbPick = randBits(2);
            if (wbPick == 32'd1) begin
                b.wbSel = WB_OUTB;
                expResult = b.outB;
            end else if (wbPick == 32'd2) begin
                b.wbSel = WB_MEM;
                expResult = addr;
            end else begin
                b.wbSel = WB_ALU;
                expResult = addr;
            end
            loadInstr(b);
            checkEq("dmemEn_o", 32'(dmemEn), 32'd1);
            checkEq("dmemWe_o", 32'(dmemWe), 32'(expWe));
            checkEq("dmemAddr_o", dmemAddr, addr);
            checkEq("dmemWdata_o", dmemWdata, expData);
            checkEq("memResult_o", memResult, expResult);
            checkEq("memDst_o", 32'(memDst), 32'(b.dst));
            checkEq("memWb_o.wbSel", 32'(memWb.wbSel), 32'(b.wbSel));
            checkRedirect(1'b0);
        end
        endTest("stores and forwarding", errs);
    endtask

    task automatic testAddrError();
        int         errs;
        exeMemBus_t b;
        word_t      addr;
        errs = errorCount;
        // Leave the handler first so the exception has to set EXL again.
        @(posedge clk);
        wbCp0Wr   <= 1'b1;
        wbCp0Addr <= `CP0_STATUS;
        wbCp0Data <= 32'h0000_0000;
        @(posedge clk);
        wbCp0Wr <= 1'b0;
        @(negedge clk);
        checkEq("Status.EXL", 32'(dut.status[`ST_EXL_BIT]), 32'd0);
        b = makeInstr();
        addr = randBits(32);
        if (addr[1:0] == 2'b00)
            addr[0] = 1'b1;
        b.aluOut = addr;
        b.storeType = ST_W;
        b.regsWr = '1;
        loadInstr(b);
        checkEq("excCode", 32'(dut.excCode), 32'(`EXC_ADES));
        checkEq("dmemWe_o", 32'(dmemWe), 32'd0);
        checkEq("dmemEn_o", 32'(dmemEn), 32'd0);
        checkRedirect(1'b1);
        checkEq("excTarget_o", excTarget, `EXC_VECTOR);
        checkEq("memWb_o.regsWr", 32'(memWb.regsWr), 32'd0);
        checkEq("memWb_o.excValid", 32'(memWb.excValid), 32'd1);
        @(negedge clk);
        checkEq("Cause.ExcCode", 32'(dut.cause[`CA_EXC_HI:`CA_EXC_LO]), 32'(`EXC_ADES));
        checkEq("Status.EXL", 32'(dut.status[`ST_EXL_BIT]), 32'd1);
        endTest("address error", errs);
    endtask

    task automatic testIntBypass();
        int         errs;
        exeMemBus_t b;
        errs = errorCount;
        b = makeInstr();
        b.except.syscall = 1'b1;
        // Line 0 feeds IP bit 10.
        @(posedge clk);
        hwInt <= 6'b000001;
        @(posedge clk);
        exeMem <= b;
        memWr  <= 1'b1;
        @(posedge clk);
        exeMem    <= '0;
        wbCp0Wr   <= 1'b1;
        wbCp0Addr <= `CP0_STATUS;
        wbCp0Data <= 32'h0000_0401;
        @(negedge clk);
        checkEq("excCode", 32'(dut.excCode), 32'(`EXC_INT));
        checkRedirect(1'b1);
        checkEq("excTarget_o", excTarget, `EXC_VECTOR);
        @(posedge clk);
        wbCp0Wr <= 1'b0;
        hwInt   <= 6'b000000;
        @(negedge clk);
        checkEq("Cause.ExcCode", 32'(dut.cause[`CA_EXC_HI:`CA_EXC_LO]), 32'(`EXC_INT));
        checkEq("Status.EXL", 32'(dut.status[`ST_EXL_BIT]), 32'd1);
        checkEq("Status.IE", 32'(dut.status[`ST_IE_BIT]), 32'd1);
        endTest("interrupt priority and bypass", errs);
    endtask

    task automatic testDelaySlot();
        int         errs;
        exeMemBus_t br;
        exeMemBus_t f;
        errs = errorCount;
        br = makeInstr();
        br.isBranch = 1'b1;
        loadInstr(br);
        checkRedirect(1'b0);
        f = makeInstr();
        f.except.overflow = 1'b1;
        expEpc = f.pc - 32'd4;
        loadInstr(f);
        checkEq("excCode", 32'(dut.excCode), 32'(`EXC_OV));
        checkEq("excEpc", dut.excEpc, expEpc);
        checkEq("excBd", 32'(dut.excBd), 32'd1);
        @(negedge clk);
        checkEq("EPC", dut.epc, expEpc);
        checkEq("Cause.BD", 32'(dut.cause[`CA_BD_BIT]), 32'd1);
        endTest("delay slot", errs);
    endtask

    task automatic testEret();
        int         errs;
        exeMemBus_t e;
        errs = errorCount;
        e = makeInstr();
        e.except.eret = 1'b1;
        loadInstr(e);
        checkEq("excTarget_o", excTarget, expEpc);
        checkRedirect(1'b1);
        checkEq("memWb_o.excValid", 32'(memWb.excValid), 32'd0);
        @(negedge clk);
        checkEq("Status.EXL", 32'(dut.status[`ST_EXL_BIT]), 32'd0);
        endTest("eret", errs);
    endtask

    initial begin
        #((ResetCycles + TestCycles) * 100 + 2000);
        $display("Watchdog expired before the tests finished");
        $display("Simulation failed");
        $finish;
    end

    initial begin
        rstN      = 1'b0;
        memWr     = 1'b0;
        memFlush  = 1'b0;
        exeMem    = '0;
        hwInt     = '0;
        wbCp0Wr   = 1'b0;
        wbCp0Addr = '0;
        wbCp0Data = '0;
        repeat (ResetCycles) @(posedge clk);
        rstN <= 1'b1;
        @(negedge clk);
        testRegControl();
        testStores();
        testAddrError();
        testIntBypass();
        testDelaySlot();
        testEret();
        $display("Tests run: %0d, tests failed: %0d, check errors: %0d",
            testCount, failedTests, errorCount);
        if (errorCount == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

//--- hw/memStage/memStage.sv
// Memory stage top: pipeline register, memory access, exception unit and CP0.
`timescale 1ns/1ps

module memStage
    import memStagePkg::*;
(
    input  logic       clk,
    input  logic       rstN_i,
    input  logic       memWr_i,
    input  logic       memFlush_i,
    input  exeMemBus_t exeMem_i,
    input  logic [5:0] hwInt_i,
    input  logic       wbCp0Wr_i,
    input  regAddr_t   wbCp0Addr_i,
    input  word_t      wbCp0Data_i,
    output memWbBus_t  memWb_o,
    output logic       dmemEn_o,
    output byteEn_t    dmemWe_o,
    output word_t      dmemAddr_o,
    output word_t      dmemWdata_o,
    output word_t      memResult_o,
    output regAddr_t   memDst_o,
    output logic       ifIdFlush_o,
    output logic       idExeFlush_o,
    output logic       exeMemFlush_o,
    output logic       isExceptOrEret_o,
    output word_t      excTarget_o
);

    exeMemBus_t memBus;
    logic       inDelaySlot;
    logic       dataAdEL;
    logic       dataAdES;
    logic       excValid;
    logic       excTake;
    excCode_t   excCode;
    logic       excBd;
    word_t      excEpc;
    logic       eretTake;
    word_t      status;
    word_t      cause;
    word_t      epc;

    memReg uMemReg (
        .clk           (clk),
        .rstN_i        (rstN_i),
        .memWr_i       (memWr_i),
        .memFlush_i    (memFlush_i),
        .exeMem_i      (exeMem_i),
        .mem_o         (memBus),
        .inDelaySlot_o (inDelaySlot)
    );

    memAccess uMemAccess (
        .mem_i       (memBus),
        .excValid_i  (excValid),
        .dataAdEL_o  (dataAdEL),
        .dataAdES_o  (dataAdES),
        .dmemEn_o    (dmemEn_o),
        .dmemWe_o    (dmemWe_o),
        .dmemAddr_o  (dmemAddr_o),
        .dmemWdata_o (dmemWdata_o),
        .memResult_o (memResult_o),
        .memDst_o    (memDst_o)
    );

    exceptionUnit uExceptionUnit (
        .mem_i            (memBus),
        .inDelaySlot_i    (inDelaySlot),
        .dataAdEL_i       (dataAdEL),
        .dataAdES_i       (dataAdES),
        .status_i         (status),
        .cause_i          (cause),
        .epc_i            (epc),
        .memWb_o          (memWb_o),
        .excValid_o       (excValid),
        .excTake_o        (excTake),
        .excCode_o        (excCode),
        .excBd_o          (excBd),
        .excEpc_o         (excEpc),
        .eretTake_o       (eretTake),
        .ifIdFlush_o      (ifIdFlush_o),
        .idExeFlush_o     (idExeFlush_o),
        .exeMemFlush_o    (exeMemFlush_o),
        .isExceptOrEret_o (isExceptOrEret_o),
        .excTarget_o      (excTarget_o)
    );

    cp0Regs uCp0Regs (
        .clk         (clk),
        .rstN_i      (rstN_i),
        .hwInt_i     (hwInt_i),
        .wbCp0Wr_i   (wbCp0Wr_i),
        .wbCp0Addr_i (wbCp0Addr_i),
        .wbCp0Data_i (wbCp0Data_i),
        .excTake_i   (excTake),
        .excCode_i   (excCode),
        .excBd_i     (excBd),
        .excEpc_i    (excEpc),
        .eretTake_i  (eretTake),
        .status_o    (status),
        .cause_o     (cause),
        .epc_o       (epc)
    );

endmodule

//--- hw/memStage/cp0Regs.sv
// CP0 Status, Cause and EPC with write-back bypass and exception/ERET updates.
`timescale 1ns/1ps
`include "memStage_params.svh"

module cp0Regs
    import memStagePkg::*;
(
    input  logic       clk,
    input  logic       rstN_i,
    input  logic [5:0] hwInt_i,
    input  logic       wbCp0Wr_i,
    input  regAddr_t   wbCp0Addr_i,
    input  word_t      wbCp0Data_i,
    input  logic       excTake_i,
    input  excCode_t   excCode_i,
    input  logic       excBd_i,
    input  word_t      excEpc_i,
    input  logic       eretTake_i,
    output word_t      status_o,
    output word_t      cause_o,
    output word_t      epc_o
);

    word_t statusQ;
    word_t causeQ;
    word_t epcQ;

    // Merge the write-back write so MEM decides on the newest values.
    always_comb begin
        status_o = statusQ;
        cause_o  = causeQ;
        epc_o    = epcQ;
        if (wbCp0Wr_i && wbCp0Addr_i == `CP0_STATUS) begin
            status_o[`ST_IM_HI:`ST_IM_LO] = wbCp0Data_i[`ST_IM_HI:`ST_IM_LO];
            status_o[`ST_EXL_BIT]         = wbCp0Data_i[`ST_EXL_BIT];
            status_o[`ST_IE_BIT]          = wbCp0Data_i[`ST_IE_BIT];
        end
        // Only the two software interrupt bits.
        if (wbCp0Wr_i && wbCp0Addr_i == `CP0_CAUSE) begin
            cause_o[`CA_IP_LO+1:`CA_IP_LO] = wbCp0Data_i[`CA_IP_LO+1:`CA_IP_LO];
        end
        if (wbCp0Wr_i && wbCp0Addr_i == `CP0_EPC) begin
            epc_o = wbCp0Data_i;
        end
    end

    always_ff @(posedge clk or negedge rstN_i) begin
        if (!rstN_i) begin
            statusQ <= `STATUS_RESET;
            causeQ  <= '0;
            epcQ    <= '0;
        end else begin
            statusQ                        <= status_o;
            causeQ                         <= cause_o;
            causeQ[`CA_IP_HI:`CA_IP_LO+2]  <= hwInt_i;
            epcQ                           <= epc_o;
            // Exception fields override a same-cycle write.
            if (excTake_i) begin
                epcQ                          <= excEpc_i;
                causeQ[`CA_EXC_HI:`CA_EXC_LO] <= excCode_i;
                causeQ[`CA_BD_BIT]            <= excBd_i;
                statusQ[`ST_EXL_BIT]          <= 1'b1;
            end else if (eretTake_i) begin
                statusQ[`ST_EXL_BIT] <= 1'b0;
            end
        end
    end

endmodule

//--- hw/memStage/exceptionUnit.sv
// Exception priority, ERET handling, pipeline flushes and write-flag masking in MEM.
`timescale 1ns/1ps
`include "memStage_params.svh"

module exceptionUnit
    import memStagePkg::*;
(
    input  exeMemBus_t mem_i,
    input  logic       inDelaySlot_i,
    input  logic       dataAdEL_i,
    input  logic       dataAdES_i,
    input  word_t      status_i,
    input  word_t      cause_i,
    input  word_t      epc_i,
    output memWbBus_t  memWb_o,
    output logic       excValid_o,
    output logic       excTake_o,
    output excCode_t   excCode_o,
    output logic       excBd_o,
    output word_t      excEpc_o,
    output logic       eretTake_o,
    output logic       ifIdFlush_o,
    output logic       idExeFlush_o,
    output logic       exeMemFlush_o,
    output logic       isExceptOrEret_o,
    output word_t      excTarget_o
);

    logic     intPending;
    logic     excTake;
    excCode_t excCode;
    logic     eretTake;
    logic     redirect;

    // Interrupts only when enabled and not already in a handler.
    assign intPending = status_i[`ST_IE_BIT] && !status_i[`ST_EXL_BIT] &&
        |(cause_i[`CA_IP_HI:`CA_IP_LO] & status_i[`ST_IM_HI:`ST_IM_LO]);

    // First match wins, interrupts first.
    always_comb begin
        excTake = 1'b0;
        excCode = `EXC_INT;
        if (mem_i.valid) begin
            excTake = 1'b1;
            if (intPending)                 excCode = `EXC_INT;
            else if (mem_i.except.fetchAdEL) excCode = `EXC_ADEL;
            else if (mem_i.except.reserved)  excCode = `EXC_RI;
            else if (mem_i.except.overflow)  excCode = `EXC_OV;
            else if (mem_i.except.syscall)   excCode = `EXC_SYS;
            else if (mem_i.except.brk)       excCode = `EXC_BP;
            else if (dataAdEL_i)             excCode = `EXC_ADEL;
            else if (dataAdES_i)             excCode = `EXC_ADES;
            else                             excTake = 1'b0;
        end
    end

    assign eretTake = mem_i.valid && mem_i.except.eret && !excTake;
    assign redirect = excTake || eretTake;

    assign excValid_o = excTake;
    assign excTake_o  = excTake;
    assign excCode_o  = excCode;
    assign excBd_o    = inDelaySlot_i;
    // Faults in a delay slot restart at the branch.
    assign excEpc_o   = inDelaySlot_i ? (mem_i.pc - 32'd4) : mem_i.pc;
    assign eretTake_o = eretTake;

    assign ifIdFlush_o      = redirect;
    assign idExeFlush_o     = redirect;
    assign exeMemFlush_o    = redirect;
    assign isExceptOrEret_o = redirect;
    assign excTarget_o      = eretTake ? epc_i : `EXC_VECTOR;

    always_comb begin
        memWb_o.valid    = mem_i.valid;
        memWb_o.aluOut   = mem_i.aluOut;
        memWb_o.outB     = mem_i.outB;
        memWb_o.pc       = mem_i.pc;
        memWb_o.hi       = mem_i.hi;
        memWb_o.lo       = mem_i.lo;
        memWb_o.dst      = mem_i.dst;
        memWb_o.loadType = mem_i.loadType;
        memWb_o.wbSel    = mem_i.wbSel;
        // A faulting or empty slot writes nothing.
        memWb_o.regsWr   = (mem_i.valid && !excTake) ? mem_i.regsWr : '0;
        memWb_o.excValid = excTake;
    end

endmodule

//--- hw/memStage/memAccess.sv
// Store alignment, address-error checks, data-memory request and MEM forwarding value.
`timescale 1ns/1ps

module memAccess
    import memStagePkg::*;
(
    input  exeMemBus_t mem_i,
    input  logic       excValid_i,
    output logic       dataAdEL_o,
    output logic       dataAdES_o,
    output logic       dmemEn_o,
    output byteEn_t    dmemWe_o,
    output word_t      dmemAddr_o,
    output word_t      dmemWdata_o,
    output word_t      memResult_o,
    output regAddr_t   memDst_o
);

    word_t   addr;
    logic    isLoad;
    logic    isStore;
    logic    misaligned;
    byteEn_t storeBe;
    logic    reqOk;

    assign addr    = mem_i.aluOut;
    assign isLoad  = (mem_i.loadType != LD_NONE);
    assign isStore = (mem_i.storeType != ST_NONE);

    // Halfwords need bit 0 clear, words need both low bits clear.
    assign misaligned =
        ((mem_i.loadType == LD_H || mem_i.loadType == LD_HU || mem_i.storeType == ST_H)
            && addr[0]) ||
        ((mem_i.loadType == LD_W || mem_i.storeType == ST_W) && (addr[1:0] != 2'b00));

    assign dataAdEL_o = mem_i.valid && isLoad && misaligned;
    assign dataAdES_o = mem_i.valid && isStore && misaligned;

    // Lane replication and byte enables, little endian.
    always_comb begin
        dmemWdata_o = mem_i.outB;
        storeBe     = 4'b0000;
        case (mem_i.storeType)
            ST_B: begin
                dmemWdata_o = {4{mem_i.outB[7:0]}};
                storeBe     = 4'b0001 << addr[1:0];
            end
            ST_H: begin
                dmemWdata_o = {2{mem_i.outB[15:0]}};
                storeBe     = addr[1] ? 4'b1100 : 4'b0011;
            end
            ST_W: storeBe = 4'b1111;
            default: storeBe = 4'b0000;
        endcase
    end

    // Any exception in MEM cancels the access.
    assign reqOk      = mem_i.valid && !excValid_i;
    assign dmemEn_o   = reqOk && (isLoad || isStore);
    assign dmemWe_o   = reqOk ? storeBe : 4'b0000;
    assign dmemAddr_o = addr;

    assign memResult_o = (mem_i.wbSel == WB_OUTB) ? mem_i.outB : mem_i.aluOut;
    assign memDst_o    = mem_i.dst;

endmodule

//--- hw/memStage/memReg.sv
// EXE/MEM pipeline register with hold, flush and branch delay-slot tracking.
`timescale 1ns/1ps

module memReg
    import memStagePkg::*;
(
    input  logic       clk,
    input  logic       rstN_i,
    input  logic       memWr_i,
    input  logic       memFlush_i,
    input  exeMemBus_t exeMem_i,
    output exeMemBus_t mem_o,
    output logic       inDelaySlot_o
);

    exeMemBus_t memBus;
    logic       memValid;
    logic       lastBranch;
    logic       inDelaySlot;

    // Control state. A flush wins over the write enable.
    always_ff @(posedge clk or negedge rstN_i) begin
        if (!rstN_i) begin
            memValid    <= 1'b0;
            lastBranch  <= 1'b0;
            inDelaySlot <= 1'b0;
        end else if (memFlush_i) begin
            memValid    <= 1'b0;
            lastBranch  <= 1'b0;
            inDelaySlot <= 1'b0;
        end else if (memWr_i) begin
            memValid <= exeMem_i.valid;
            // Bubbles do not disturb the branch history.
            if (exeMem_i.valid) begin
                inDelaySlot <= lastBranch;
                lastBranch  <= exeMem_i.isBranch;
            end
        end
    end

    // Payload follows the same enable.
    always_ff @(posedge clk) begin
        if (memWr_i && !memFlush_i) begin
            memBus <= exeMem_i;
        end
    end

    always_comb begin
        mem_o       = memBus;
        mem_o.valid = memValid;
    end

    assign inDelaySlot_o = inDelaySlot;

endmodule

//--- common/memStagePkg.sv
// Shared types for the MIPS memory stage: words, opcode selectors and pipeline buses.
package memStagePkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  regAddr_t;
    typedef logic [4:0]  excCode_t;
    typedef logic [3:0]  byteEn_t;

    // Load kind, kept for the write-back aligner.
    typedef enum logic [2:0] {
        LD_NONE,
        LD_B,
        LD_BU,
        LD_H,
        LD_HU,
        LD_W
    } loadType_t;

    typedef enum logic [1:0] {
        ST_NONE,
        ST_B,
        ST_H,
        ST_W
    } storeType_t;

    // Source of the value written back.
    typedef enum logic [1:0] {
        WB_ALU,
        WB_OUTB,
        WB_MEM
    } wbSel_t;

    typedef struct packed {
        logic regWr;
        logic cp0Wr;
        logic hiWr;
        logic loWr;
    } regsWr_t;

    // Exceptions raised in earlier stages.
    typedef struct packed {
        logic fetchAdEL;
        logic reserved;
        logic overflow;
        logic syscall;
        logic brk;
        logic eret;
    } exceptFlags_t;

    typedef struct packed {
        logic         valid;
        word_t        aluOut;
        word_t        outB;
        word_t        pc;
        word_t        hi;
        word_t        lo;
        regAddr_t     dst;
        logic         isBranch;
        loadType_t    loadType;
        storeType_t   storeType;
        wbSel_t       wbSel;
        regsWr_t      regsWr;
        exceptFlags_t except;
    } exeMemBus_t;

    typedef struct packed {
        logic      valid;
        word_t     aluOut;
        word_t     outB;
        word_t     pc;
        word_t     hi;
        word_t     lo;
        regAddr_t  dst;
        loadType_t loadType;
        wbSel_t    wbSel;
        regsWr_t   regsWr;
        logic      excValid;
    } memWbBus_t;

endpackage

//--- common/memStage_params.svh
// Exception codes, CP0 register numbers and CP0 field positions for the memory stage.
`ifndef MEMSTAGE_PARAMS_SVH
`define MEMSTAGE_PARAMS_SVH

// Exception codes.
`define EXC_INT  5'd0
`define EXC_ADEL 5'd4
`define EXC_ADES 5'd5
`define EXC_SYS  5'd8
`define EXC_BP   5'd9
`define EXC_RI   5'd10
`define EXC_OV   5'd12

// CP0 register numbers.
`define CP0_STATUS 5'd12
`define CP0_CAUSE  5'd13
`define CP0_EPC    5'd14

// Status fields.
`define ST_IE_BIT  0
`define ST_EXL_BIT 1
`define ST_IM_HI   15
`define ST_IM_LO   8
`define STATUS_RESET 32'h00400002

// Cause fields.
`define CA_IP_HI   15
`define CA_IP_LO   8
`define CA_EXC_HI  6
`define CA_EXC_LO  2
`define CA_BD_BIT  31

`define EXC_VECTOR 32'hBFC00380

`endif
